// File: logic/stream_buffer_pkg.sv
`default_nettype none

package stream_buffer_pkg;

	localparam int DATA_W = 16;  // Feature word width.
	localparam int ADDR_W = 14;  // Bank address width.

	// Feature word as held in either bank.
	typedef logic [DATA_W-1:0] feature_t;

	// Word address into a bank.
	typedef logic [ADDR_W-1:0] bank_addr_t;

	// Run state of the stream buffer.
	typedef enum logic {
		ST_SCAN,  // Pass in progress.
		ST_DONE   // Pass complete, scan frozen.
	} run_state_t;

endpackage

`default_nettype wire

// File: logic/stream_buffer_ctrl.sv
`default_nettype none

module stream_buffer_ctrl (
	input  wire  clk,
	input  wire  i_reset,
	input  wire  i_pass_last,
	output logic o_run,
	output logic o_feature_valid
);

	import stream_buffer_pkg::*;

	// Matches the registered read path of the banks.
	localparam int RD_LAT = 4;

	run_state_t state;
	logic [RD_LAT-1:0] run_dly;

	// One pass per reset.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= ST_SCAN;
		end else begin
			case (state)
				ST_SCAN: begin
					if (i_pass_last) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					state <= ST_DONE;  // Only reset leaves here.
				end
				default: begin
					state <= ST_SCAN;
				end
			endcase
		end
	end

	assign o_run = (state == ST_SCAN);

	// Run level delayed to line up with the bank outputs.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			run_dly <= '0;
		end else begin
			run_dly <= {run_dly[RD_LAT-2:0], o_run};
		end
	end

	assign o_feature_valid = run_dly[RD_LAT-1];

endmodule

`default_nettype wire

// File: logic/scan_addr_gen.sv
`default_nettype none

module scan_addr_gen #(
	parameter int L_LEN      = 4,
	parameter int C_LEN      = 3,
	parameter int W_LEN      = 5,
	parameter int ROW_STRIDE = 4
) (
	input  wire                           clk,
	input  wire                           i_reset,
	input  wire                           i_run,
	output stream_buffer_pkg::bank_addr_t o_addr,
	output logic                          o_pass_last
);

	import stream_buffer_pkg::*;

	localparam int L_W = (L_LEN > 1) ? $clog2(L_LEN) : 1;
	localparam int C_W = (C_LEN > 1) ? $clog2(C_LEN) : 1;
	localparam int W_W = (W_LEN > 1) ? $clog2(W_LEN) : 1;
	localparam bank_addr_t STRIDE = bank_addr_t'(ROW_STRIDE);

	logic [L_W-1:0] lane_cnt;
	logic [C_W-1:0] chan_cnt;
	logic [W_W-1:0] col_cnt;

	bank_addr_t offset;    // Lane offset within the window.
	bank_addr_t base;      // Column start plus channel.
	bank_addr_t col_base;  // Start of the current column.
	bank_addr_t next_col;

	logic lane_last;
	logic chan_last;
	logic col_last;

	assign lane_last = (lane_cnt == L_W'(L_LEN - 1));
	assign chan_last = (chan_cnt == C_W'(C_LEN - 1));
	assign col_last  = (col_cnt == W_W'(W_LEN - 1));
	assign next_col  = col_base + STRIDE;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			lane_cnt <= '0;
			chan_cnt <= '0;
			col_cnt  <= '0;
			offset   <= '0;
			base     <= '0;
			col_base <= '0;
		end else if (i_run) begin
			if (lane_last && chan_last && col_last) begin
				// Last step of the pass, wrap to the start.
				lane_cnt <= '0;
				chan_cnt <= '0;
				col_cnt  <= '0;
				offset   <= '0;
				base     <= '0;
				col_base <= '0;
			end else if (lane_last && chan_last) begin
				lane_cnt <= '0;
				chan_cnt <= '0;
				col_cnt  <= col_cnt + 1'b1;
				offset   <= '0;
				base     <= next_col;  // Next column start.
				col_base <= next_col;
			end else if (lane_last) begin
				lane_cnt <= '0;
				chan_cnt <= chan_cnt + 1'b1;
				offset   <= '0;
				base     <= base + 1'b1;
			end else begin
				lane_cnt <= lane_cnt + 1'b1;
				offset   <= offset + 1'b1;
			end
		end
	end

	assign o_addr      = base + offset;
	assign o_pass_last = i_run && lane_last && chan_last && col_last;

endmodule

`default_nettype wire

// File: logic/feature_bank.sv
`default_nettype none

module feature_bank #(
	parameter int DEPTH = 64
) (
	input  wire                           clk,
	input  wire                           i_wen,
	input  wire stream_buffer_pkg::bank_addr_t i_waddr,
	input  wire stream_buffer_pkg::bank_addr_t i_raddr,
	input  wire stream_buffer_pkg::feature_t   i_wdata,
	output stream_buffer_pkg::feature_t        o_rdata
);

	import stream_buffer_pkg::*;

	// Index bits actually used by the memory.
	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	feature_t mem [DEPTH];

	bank_addr_t raddr_q;  // Stage 1.
	feature_t   mem_q;    // Stage 2.
	feature_t   data_q;   // Stage 3.

	// Write port.
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr[IDX_W-1:0]] <= i_wdata;
		end
	end

	// Read port.
	// A write in the cycle the address register is loaded is seen.
	// One in the cycle after is not.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		mem_q   <= mem[raddr_q[IDX_W-1:0]];
		data_q  <= mem_q;
		o_rdata <= data_q;  // Stage 4.
	end

endmodule

`default_nettype wire

// File: logic/result_bank.sv
`default_nettype none

module result_bank #(
	parameter int DEPTH = 64
) (
	input  wire                                clk,
	input  wire                                i_wen,
	input  wire stream_buffer_pkg::bank_addr_t i_waddr,
	input  wire stream_buffer_pkg::bank_addr_t i_raddr,
	input  wire stream_buffer_pkg::feature_t   i_pool,
	input  wire stream_buffer_pkg::feature_t   i_eltwise,
	input  wire                                i_eltwise_sel,
	output stream_buffer_pkg::feature_t        o_rdata
);

	import stream_buffer_pkg::*;

	feature_t wb_data;  // Selected write-back word.

	always_comb begin
		if (i_eltwise_sel) begin
			wb_data = i_eltwise;
		end else begin
			wb_data = i_pool;
		end
	end

	feature_bank #(
		.DEPTH(DEPTH)
	) bank_i (
		.clk    (clk),
		.i_wen  (i_wen),
		.i_waddr(i_waddr),
		.i_raddr(i_raddr),
		.i_wdata(wb_data),
		.o_rdata(o_rdata)
	);

endmodule

`default_nettype wire

// File: logic/stream_buffer.sv
`default_nettype none

module stream_buffer #(
	parameter int L_LEN      = 4,
	parameter int C_LEN      = 4,
	parameter int W_LEN      = 110,
	parameter int ROW_STRIDE = 110,
	parameter int DEPTH      = 12100
) (
	input  wire                                clk,
	input  wire                                i_reset,
	input  wire                                i_wen0,
	input  wire                                i_wen1,
	input  wire stream_buffer_pkg::feature_t   i_ddr,
	input  wire stream_buffer_pkg::feature_t   i_pool,
	input  wire                                i_eltwise_sel,
	input  wire stream_buffer_pkg::feature_t   i_eltwise,
	input  wire stream_buffer_pkg::bank_addr_t i_waddr,
	output stream_buffer_pkg::feature_t        o_feature_0,
	output stream_buffer_pkg::feature_t        o_feature_1,
	output logic                               o_feature_valid
);

	import stream_buffer_pkg::*;

	logic       run;
	logic       pass_last;
	bank_addr_t scan_addr;  // Shared by both banks.

	stream_buffer_ctrl ctrl_i (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_pass_last    (pass_last),
		.o_run          (run),
		.o_feature_valid(o_feature_valid)
	);

	scan_addr_gen #(
		.L_LEN     (L_LEN),
		.C_LEN     (C_LEN),
		.W_LEN     (W_LEN),
		.ROW_STRIDE(ROW_STRIDE)
	) scan_i (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_run      (run),
		.o_addr     (scan_addr),
		.o_pass_last(pass_last)
	);

	// Input bank, loaded from DDR at the scan address.
	feature_bank #(
		.DEPTH(DEPTH)
	) bank0_i (
		.clk    (clk),
		.i_wen  (i_wen0),
		.i_waddr(scan_addr),
		.i_raddr(scan_addr),
		.i_wdata(i_ddr),
		.o_rdata(o_feature_0)
	);

	// Write-back bank.
	result_bank #(
		.DEPTH(DEPTH)
	) bank1_i (
		.clk          (clk),
		.i_wen        (i_wen1),
		.i_waddr      (i_waddr),
		.i_raddr      (scan_addr),
		.i_pool       (i_pool),
		.i_eltwise    (i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.o_rdata      (o_feature_1)
	);

endmodule

`default_nettype wire

// File: dv/stream_buffer_tb.sv
`default_nettype none

module stream_buffer_tb;

	import stream_buffer_pkg::*;

	localparam int L_LEN         = 4;
	localparam int C_LEN         = 3;
	localparam int W_LEN         = 5;
	localparam int ROW_STRIDE    = 4;
	localparam int DEPTH         = 64;
	localparam int N             = W_LEN * C_LEN * L_LEN;
	localparam int RD_LAT        = 4;
	localparam int TAIL          = 12;  // Frozen cycles checked after valid falls.
	localparam int VALID_TIMEOUT = 4 * N;
	localparam bit [31:0] SEED   = 32'h2809b220;

	logic       clk;
	logic       i_reset;
	logic       i_wen0;
	logic       i_wen1;
	feature_t   i_ddr;
	feature_t   i_pool;
	logic       i_eltwise_sel;
	feature_t   i_eltwise;
	bank_addr_t i_waddr;
	feature_t   o_feature_0;
	feature_t   o_feature_1;
	logic       o_feature_valid;

	// Reference banks and which words hold known data.
	feature_t mem0 [DEPTH];
	feature_t mem1 [DEPTH];
	bit       known0 [DEPTH];
	bit       known1 [DEPTH];

	// Expected read words per cycle, top bit marks a known word.
	logic [DATA_W:0] exp0_q [$];
	logic [DATA_W:0] exp1_q [$];

	int prev_addr;    // Scan address of the previous cycle.
	int data_checks;

	stream_buffer #(
		.L_LEN     (L_LEN),
		.C_LEN     (C_LEN),
		.W_LEN     (W_LEN),
		.ROW_STRIDE(ROW_STRIDE),
		.DEPTH     (DEPTH)
	) dut_i (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_wen0         (i_wen0),
		.i_wen1         (i_wen1),
		.i_ddr          (i_ddr),
		.i_pool         (i_pool),
		.i_eltwise_sel  (i_eltwise_sel),
		.i_eltwise      (i_eltwise),
		.i_waddr        (i_waddr),
		.o_feature_0    (o_feature_0),
		.o_feature_1    (o_feature_1),
		.o_feature_valid(o_feature_valid)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Window address of step k.
	function automatic int scan_addr(input int k);
		int l;
		int c;
		int w;
		l = k % L_LEN;
		c = (k / L_LEN) % C_LEN;
		w = k / (L_LEN * C_LEN);
		return w * ROW_STRIDE + c + l;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("FAIL %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
			$display("sim failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR: timed out waiting for %s", what);
		$display("sim failed");
		$fatal(1, "timeout");
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		i_wen0  = 1'b0;
		i_wen1  = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		i_reset = 1'b0;  // Cycle 0 starts here.
		exp0_q.delete();
		exp1_q.delete();
	endtask

	// Mode 0 loads both banks, 1 only reads, 2 mixes reads and writes.
	task automatic drive_inputs(input int mode, input int j);
		int pick;
		i_ddr         = feature_t'($urandom);
		i_pool        = feature_t'($urandom);
		i_eltwise     = feature_t'($urandom);
		i_eltwise_sel = 1'($urandom);
		i_wen0        = 1'b0;
		i_wen1        = 1'b0;
		pick = int'($urandom_range(3, 0));
		case (pick)
			0: i_waddr = bank_addr_t'(prev_addr);  // Word read in the last cycle.
			1: i_waddr = bank_addr_t'($urandom_range(DEPTH - 1, 0));
			default: i_waddr = bank_addr_t'($urandom_range(scan_addr(N - 1), 0));
		endcase
		if (j < N) begin
			if (mode == 0) begin
				i_wen0 = ($urandom_range(7, 0) != 0);
				i_wen1 = ($urandom_range(7, 0) != 0);
			end else if (mode == 2) begin
				i_wen0 = 1'($urandom);
				i_wen1 = 1'($urandom);
			end
		end
	endtask

	// Writes of cycle j land first, then the read of cycle j is queued.
	task automatic model_cycle(input int j);
		int ra;
		int wa;
		ra = (j < N) ? scan_addr(j) : 0;
		wa = int'(i_waddr) % DEPTH;
		if (i_wen0) begin
			mem0[ra]   = i_ddr;
			known0[ra] = 1'b1;
		end
		if (i_wen1) begin
			mem1[wa]   = i_eltwise_sel ? i_eltwise : i_pool;
			known1[wa] = 1'b1;
		end
		exp0_q.push_back({known0[ra], mem0[ra]});
		exp1_q.push_back({known1[ra], mem1[ra]});
		prev_addr = ra;
	endtask

	task automatic run_pass(input int mode);
		int              j;
		int              fall_at;
		bit              rise_seen;
		bit              exp_valid;
		logic [DATA_W:0] e0;
		logic [DATA_W:0] e1;
		run_state_t      st;
		fall_at   = -1;
		rise_seen = 1'b0;
		apply_reset();
		for (j = 0; j < VALID_TIMEOUT; j++) begin
			exp_valid = (j >= RD_LAT) && (j < N + RD_LAT);
			check_equal("o_feature_valid", 32'(exp_valid), 32'(o_feature_valid));
			if (j >= RD_LAT) begin
				e0 = exp0_q.pop_front();
				e1 = exp1_q.pop_front();
				if (e0[DATA_W]) begin
					check_equal("o_feature_0", 32'(e0[DATA_W-1:0]), 32'(o_feature_0));
					data_checks++;
				end
				if (e1[DATA_W]) begin
					check_equal("o_feature_1", 32'(e1[DATA_W-1:0]), 32'(o_feature_1));
					data_checks++;
				end
			end
			if (o_feature_valid) begin
				rise_seen = 1'b1;
			end else if (rise_seen && fall_at < 0) begin
				fall_at = j;
			end
			if (fall_at >= 0 && j >= fall_at + TAIL) begin
				break;
			end
			drive_inputs(mode, j);
			model_cycle(j);
			@(posedge clk);
			#1;
		end
		if (j >= VALID_TIMEOUT) begin
			report_timeout("o_feature_valid to fall at the end of the pass");
		end
		st = dut_i.ctrl_i.state;
		$display("Pass in mode %0d ended in %s", mode, st.name());
	endtask

	initial begin
		void'($urandom(SEED));
		i_reset       = 1'b1;
		i_wen0        = 1'b0;
		i_wen1        = 1'b0;
		i_ddr         = '0;
		i_pool        = '0;
		i_eltwise_sel = 1'b0;
		i_eltwise     = '0;
		i_waddr       = '0;
		prev_addr     = 0;
		data_checks   = 0;
		for (int a = 0; a < DEPTH; a++) begin
			known0[a] = 1'b0;
			known1[a] = 1'b0;
		end
		run_pass(0);  // Load.
		run_pass(1);  // Read back.
		run_pass(2);
		if (data_checks < N) begin
			$display("ERROR: only %0d data words were checked", data_checks);
			$display("sim failed");
			$fatal(1, "too few data checks");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: stream_buffer.f
logic/stream_buffer_pkg.sv
logic/stream_buffer_ctrl.sv
logic/scan_addr_gen.sv
logic/feature_bank.sv
logic/result_bank.sv
logic/stream_buffer.sv
dv/stream_buffer_tb.sv

// File: Makefile
# Verilator build and run of the stream buffer testbench.

VERILATOR ?= verilator
TOP       ?= stream_buffer_tb
FLIST     ?= stream_buffer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Overridable: VERILATOR TOP FLIST BUILD_DIR VFLAGS SIM"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)
